/* list.f */
+incdir+source
source/sya_pkg.sv
source/sya_pe.sv
source/sya_pe_array.sv
source/sya_loop_ctrl.sv
source/sya_ofm_writer.sv
source/sya_top.sv
test/tb_sya_glb.sv
test/tb_sya.sv

/* run.sh */
#!/bin/sh
# Builds the systolic array testbench with Verilator and runs it

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sya -Mdir "$BUILD_DIR" -o tb_sya_sim \
    -f list.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_sya_sim" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Result: FAILED" "$SIM_LOG"; then
    echo "Simulation reported a failing check"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi
if ! grep -q "Result: PASSED" "$SIM_LOG"; then
    echo "No pass result found in $SIM_LOG"
    exit 1
fi
exit 0

/* test/tb_sya.sv */
`timescale 1ns/1ns
`include "sya_macros.svh"
`default_nettype none

module tb_sya;
    import sya_pkg::*;

    logic     clk       = 1'b0;
    logic     rst_n     = 1'b0;
    sya_cfg_t cfg       = '0;
    logic     cfg_valid = 1'b0;
    logic     ofm_ready = 1'b0;
    logic     cfg_ready;
    rd_req_t  rd_req;
    logic     rd_req_valid;
    logic     rd_req_ready;
    rd_dat_t  rd_dat;
    logic     rd_dat_valid;
    logic     rd_dat_ready;
    ofm_wr_t  ofm;
    logic     ofm_valid;

    sya_cfg_t cfg_a;
    sya_cfg_t cfg_b;
    rd_req_t  req_exp [$];
    ofm_wr_t  row_exp [$];
    int       req_idx        = 0;
    int       row_idx        = 0;
    int       req_cnt_exp    = 0;
    int       cycles         = 0;
    int       timeout_cycles = 0;

    sya_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg          (cfg),
        .cfg_valid    (cfg_valid),
        .cfg_ready    (cfg_ready),
        .rd_req       (rd_req),
        .rd_req_valid (rd_req_valid),
        .rd_req_ready (rd_req_ready),
        .rd_dat       (rd_dat),
        .rd_dat_valid (rd_dat_valid),
        .rd_dat_ready (rd_dat_ready),
        .ofm          (ofm),
        .ofm_valid    (ofm_valid),
        .ofm_ready    (ofm_ready)
    );

    tb_sya_glb u_glb (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_req       (rd_req),
        .rd_req_valid (rd_req_valid),
        .rd_req_ready (rd_req_ready),
        .rd_dat       (rd_dat),
        .rd_dat_valid (rd_dat_valid),
        .rd_dat_ready (rd_dat_ready)
    );

    always #50 clk = ~clk;

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // ========================================================================
    // Reference model
    // ========================================================================
    function automatic int act_byte(input int addr, input int r);
        int v;
        v = (addr * 7 + r * 13 + 5) & 255;
        return (v > 127) ? v - 256 : v;
    endfunction

    function automatic int wgt_byte(input int addr, input int c);
        return ((addr * 11 + c * 3 + 9) & 255) - 128;
    endfunction

    // Negative sums give only the zero point
    function automatic logic [7:0] requant(input int sum, input logic [7:0] shift,
                                           input logic [7:0] zp);
        int q;
        if (sum < 0) begin
            q = 0;
        end else begin
            q = (sum >> shift) & 255;
        end
        return 8'(q + zp);
    endfunction

    function automatic sya_cfg_t make_cfg(input logic [15:0] act_base,
                                          input logic [15:0] wgt_base,
                                          input logic [15:0] ofm_base,
                                          input logic [7:0] shift,
                                          input logic [7:0] zp,
                                          input loop_ord_t ord);
        sya_cfg_t c;
        c.act_base    = act_base;
        c.wgt_base    = wgt_base;
        c.ofm_base    = ofm_base;
        c.num_chn     = 16'd2;
        c.num_grp     = 16'd2;
        c.num_til_ifm = 16'd2;
        c.num_til_flt = 16'd2;
        c.shift       = shift;
        c.zp          = zp;
        c.loop_ord    = ord;
        return c;
    endfunction

    function automatic int cycle_budget(input sya_cfg_t c);
        int blocks;
        blocks = c.num_grp * c.num_til_ifm * c.num_til_flt;
        return blocks * (c.num_chn * 20 + 60);
    endfunction

    task automatic build_expect(input sya_cfg_t c);
        int n_outer;
        int n_inner;
        int til_ifm;
        int til_flt;
        int a_addr;
        int w_addr;
        int blk;
        int sums [`SYA_NUM_ROW][`SYA_NUM_COL];
        rd_req_t req;
        ofm_wr_t row;
        blk     = 0;
        n_outer = (c.loop_ord == LOOP_FLT_INNER) ? c.num_til_ifm : c.num_til_flt;
        n_inner = (c.loop_ord == LOOP_FLT_INNER) ? c.num_til_flt : c.num_til_ifm;
        for (int o = 0; o < n_outer; o++) begin
            for (int i = 0; i < n_inner; i++) begin
                for (int g = 0; g < c.num_grp; g++) begin
                    til_ifm = (c.loop_ord == LOOP_FLT_INNER) ? o : i;
                    til_flt = (c.loop_ord == LOOP_FLT_INNER) ? i : o;
                    for (int r = 0; r < `SYA_NUM_ROW; r++) begin
                        for (int k = 0; k < `SYA_NUM_COL; k++) begin
                            sums[r][k] = 0;
                        end
                    end
                    for (int ch = 0; ch < c.num_chn; ch++) begin
                        a_addr = (c.act_base + c.num_chn * c.num_grp * til_ifm
                                 + c.num_chn * g + ch) & 32'hffff;
                        w_addr = (c.wgt_base + c.num_chn * c.num_grp * til_flt
                                 + c.num_chn * g + ch) & 32'hffff;
                        req.act_addr = 16'(a_addr);
                        req.wgt_addr = 16'(w_addr);
                        req_exp.push_back(req);
                        for (int r = 0; r < `SYA_NUM_ROW; r++) begin
                            for (int k = 0; k < `SYA_NUM_COL; k++) begin
                                sums[r][k] += act_byte(a_addr, r) * wgt_byte(w_addr, k);
                            end
                        end
                    end
                    for (int r = 0; r < `SYA_NUM_ROW; r++) begin
                        row.addr = 16'(c.ofm_base + blk * `SYA_NUM_ROW + r);
                        for (int k = 0; k < `SYA_NUM_COL; k++) begin
                            row.dat[k] = requant(sums[r][k], c.shift, c.zp);
                        end
                        row_exp.push_back(row);
                    end
                    blk++;
                end
            end
        end
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================
    task automatic send_cfg(input sya_cfg_t c);
        // Start only from an idle controller
        @(negedge clk);
        while (!cfg_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        build_expect(c);
        cfg         <= c;
        cfg_valid   <= 1'b1;
        req_cnt_exp <= req_exp.size();
        @(negedge clk);
        while (!cfg_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        cfg_valid <= 1'b0;
    endtask

    always @(posedge clk) begin
        ofm_ready <= rst_n && (($urandom % 4) != 0);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > timeout_cycles) begin
            stop_with_failure($sformatf("Timeout: run not finished within %0d cycles",
                                        timeout_cycles));
        end
    end

    // ========================================================================
    // Checks
    // ========================================================================
    always @(posedge clk) begin
        if (rst_n && rd_req_valid && rd_req_ready) begin
            assert (req_idx < req_exp.size())
                else stop_with_failure("Read request accepted beyond the expected sequence");
            assert (rd_req == req_exp[req_idx])
                else stop_with_failure($sformatf(
                    "** Error at %0t ns: request %0d act %h wgt %h, expected act %h wgt %h",
                    $time, req_idx, rd_req.act_addr, rd_req.wgt_addr,
                    req_exp[req_idx].act_addr, req_exp[req_idx].wgt_addr));
            req_idx <= req_idx + 1;
        end
    end

    always @(posedge clk) begin
        if (rst_n && ofm_valid && ofm_ready) begin
            assert (row_idx < row_exp.size())
                else stop_with_failure("Ofm row written beyond the expected sequence");
            assert (ofm == row_exp[row_idx])
                else stop_with_failure($sformatf(
                    "** Error at %0t ns: ofm row %0d addr %h dat %h, expected addr %h dat %h",
                    $time, row_idx, ofm.addr, ofm.dat,
                    row_exp[row_idx].addr, row_exp[row_idx].dat));
            row_idx <= row_idx + 1;
        end
    end

    // Reset values hold one edge after any reset cycle
    assert property (@(posedge clk) !rst_n |=> cfg_ready && !rd_req_valid && !ofm_valid)
        else stop_with_failure($sformatf("** Error at %0t ns: outputs not at reset values",
                                         $time));

    assert property (@(posedge clk) disable iff (!rst_n)
        ofm_valid && !ofm_ready |=> ofm_valid && $stable(ofm))
        else stop_with_failure($sformatf("** Error at %0t ns: ofm changed while stalled",
                                         $time));

    // Every beat belongs to the block being fed, so none waits
    assert property (@(posedge clk) disable iff (!rst_n)
        rd_dat_valid |-> rd_dat_ready)
        else stop_with_failure($sformatf("** Error at %0t ns: read data beat refused",
                                         $time));

    // Idle controller means every request of the run went out
    assert property (@(posedge clk) disable iff (!rst_n)
        cfg_ready && !cfg_valid |-> req_idx == req_cnt_exp)
        else stop_with_failure($sformatf(
            "** Error at %0t ns: cfg_ready high after %0d of %0d requests",
            $time, req_idx, req_cnt_exp));

    initial begin
        void'($urandom(32'h7712));
        cfg_a = make_cfg(16'h0100, 16'h0800, 16'h2000, 8'd4, 8'h15, LOOP_FLT_INNER);
        cfg_b = make_cfg(16'h0340, 16'h0a10, 16'h2400, 8'd3, 8'hc8, LOOP_IFM_INNER);
        timeout_cycles = cycle_budget(cfg_a) + cycle_budget(cfg_b) + 500;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        send_cfg(cfg_a);
        send_cfg(cfg_b);
        @(negedge clk);
        while (row_idx < row_exp.size() || !cfg_ready) begin
            @(negedge clk);
        end
        if (req_idx == req_exp.size() && !ofm_valid && !rd_req_valid) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stop_with_failure("Run ended with read requests or ofm rows outstanding");
        end
    end

endmodule

`default_nettype wire

/* test/tb_sya_glb.sv */
`timescale 1ns/1ns
`include "sya_macros.svh"
`default_nettype none

module tb_sya_glb (
    input  logic             clk,
    input  logic             rst_n,
    input  sya_pkg::rd_req_t rd_req,
    input  logic             rd_req_valid,
    output logic             rd_req_ready,
    output sya_pkg::rd_dat_t rd_dat,
    output logic             rd_dat_valid,
    input  logic             rd_dat_ready
);
    import sya_pkg::*;

    localparam int MAX_DELAY = 6;

    // Accepted requests waiting for their data beat
    logic [`SYA_ADDR_W-1:0] act_q [$];
    logic [`SYA_ADDR_W-1:0] wgt_q [$];
    int                     due_q [$];
    int                     now;
    int                     due;
    int                     last_due;

    // Buffer contents are a function of the address
    function automatic rd_dat_t read_word(input logic [`SYA_ADDR_W-1:0] act_addr,
                                          input logic [`SYA_ADDR_W-1:0] wgt_addr);
        rd_dat_t w;
        for (int r = 0; r < `SYA_NUM_ROW; r++) begin
            w.act[r] = 8'(act_addr * 7 + r * 13 + 5);
        end
        for (int c = 0; c < `SYA_NUM_COL; c++) begin
            w.wgt[c] = 8'(8'(wgt_addr * 11 + c * 3 + 9) - 8'd128);
        end
        return w;
    endfunction

    initial begin
        rd_req_ready = 1'b0;
        rd_dat_valid = 1'b0;
        rd_dat       = '0;
        now          = 0;
        last_due     = 0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            rd_req_ready <= 1'b0;
            rd_dat_valid <= 1'b0;
            act_q.delete();
            wgt_q.delete();
            due_q.delete();
        end else begin
            now = now + 1;
            rd_req_ready <= (($urandom % 4) != 0);
            if (rd_req_valid && rd_req_ready) begin
                // Never earlier than the beat before, keeps data in order
                due = now + 1 + ($urandom % MAX_DELAY);
                if (due < last_due) begin
                    due = last_due;
                end
                last_due = due;
                act_q.push_back(rd_req.act_addr);
                wgt_q.push_back(rd_req.wgt_addr);
                due_q.push_back(due);
            end
            // Beat holds until the controller takes it
            if (!rd_dat_valid || rd_dat_ready) begin
                if (due_q.size() > 0 && due_q[0] <= now) begin
                    rd_dat       <= read_word(act_q.pop_front(), wgt_q.pop_front());
                    rd_dat_valid <= 1'b1;
                    void'(due_q.pop_front());
                end else begin
                    rd_dat_valid <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/sya_top.sv */
`timescale 1ns/1ns
`include "sya_macros.svh"
`default_nettype none

module sya_top (
    input  logic              clk,
    input  logic              rst_n,
    input  sya_pkg::sya_cfg_t cfg,
    input  logic              cfg_valid,
    output logic              cfg_ready,
    output sya_pkg::rd_req_t  rd_req,
    output logic              rd_req_valid,
    input  logic              rd_req_ready,
    input  sya_pkg::rd_dat_t  rd_dat,
    input  logic              rd_dat_valid,
    output logic              rd_dat_ready,
    output sya_pkg::ofm_wr_t  ofm,
    output logic              ofm_valid,
    input  logic              ofm_ready
);
    import sya_pkg::*;

    logic        step_en;
    logic        step_vld;
    logic        clear;
    psum_block_t psums;
    blk_t        blk;
    logic        blk_valid;
    logic        blk_ready;

    sya_loop_ctrl u_loop_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg          (cfg),
        .cfg_valid    (cfg_valid),
        .cfg_ready    (cfg_ready),
        .rd_req       (rd_req),
        .rd_req_valid (rd_req_valid),
        .rd_req_ready (rd_req_ready),
        .rd_dat_valid (rd_dat_valid),
        .rd_dat_ready (rd_dat_ready),
        .step_en      (step_en),
        .step_vld     (step_vld),
        .clear        (clear),
        .psums        (psums),
        .blk          (blk),
        .blk_valid    (blk_valid),
        .blk_ready    (blk_ready)
    );

    // Read data goes straight into the skew stage
    sya_pe_array u_pe_array (
        .clk      (clk),
        .rst_n    (rst_n),
        .step_en  (step_en),
        .step_vld (step_vld),
        .clear    (clear),
        .act_in   (rd_dat.act),
        .wgt_in   (rd_dat.wgt),
        .psums    (psums)
    );

    sya_ofm_writer u_ofm_writer (
        .clk       (clk),
        .rst_n     (rst_n),
        .blk       (blk),
        .blk_valid (blk_valid),
        .blk_ready (blk_ready),
        .ofm       (ofm),
        .ofm_valid (ofm_valid),
        .ofm_ready (ofm_ready)
    );

endmodule

`default_nettype wire

/* source/sya_ofm_writer.sv */
`timescale 1ns/1ns
`include "sya_macros.svh"
`default_nettype none

module sya_ofm_writer (
    input  logic             clk,
    input  logic             rst_n,
    input  sya_pkg::blk_t    blk,
    input  logic             blk_valid,
    output logic             blk_ready,
    output sya_pkg::ofm_wr_t ofm,
    output logic             ofm_valid,
    input  logic             ofm_ready
);
    import sya_pkg::*;

    localparam int ROW_W = $clog2(`SYA_NUM_ROW);

    blk_t                                     blk_q;
    logic                                     full;
    logic [ROW_W-1:0]                         row;
    logic [`SYA_NUM_COL-1:0][`SYA_PSUM_W-1:0] row_sums;

    // One block in flight, next one waits for the last row
    assign blk_ready = !full;
    assign ofm_valid = full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
            row  <= '0;
        end else if (blk_valid && blk_ready) begin
            full <= 1'b1;
            row  <= '0;
        end else if (ofm_valid && ofm_ready) begin
            if (row == ROW_W'(`SYA_NUM_ROW - 1)) begin
                full <= 1'b0;
            end
            row <= row + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (blk_valid && blk_ready) begin
            blk_q <= blk;
        end
    end

    // ========================================================================
    // Requantization
    // ========================================================================
    assign row_sums = blk_q.psums[row];

    always_comb begin
        ofm.addr = blk_q.ofm_addr + `SYA_ADDR_W'(row);
        // Negative sums clamp to zero before the zero point is added
        for (int c = 0; c < `SYA_NUM_COL; c++) begin
            ofm.dat[c] = (row_sums[c][`SYA_PSUM_W-1] ?
                          '0 : `SYA_ACT_W'(row_sums[c] >> blk_q.shift)) + blk_q.zp;
        end
    end

    // Row holds under back-pressure
    assert property (@(posedge clk) disable iff (!rst_n)
        ofm_valid && !ofm_ready |=> ofm_valid && $stable(ofm));

endmodule

`default_nettype wire

/* source/sya_loop_ctrl.sv */
`timescale 1ns/1ns
`include "sya_macros.svh"
`default_nettype none

module sya_loop_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  sya_pkg::sya_cfg_t    cfg,
    input  logic                 cfg_valid,
    output logic                 cfg_ready,
    output sya_pkg::rd_req_t     rd_req,
    output logic                 rd_req_valid,
    input  logic                 rd_req_ready,
    input  logic                 rd_dat_valid,
    output logic                 rd_dat_ready,
    output logic                 step_en,
    output logic                 step_vld,
    output logic                 clear,
    input  sya_pkg::psum_block_t psums,
    output sya_pkg::blk_t        blk,
    output logic                 blk_valid,
    input  logic                 blk_ready
);
    import sya_pkg::*;

    localparam int FLUSH_LEN = `SYA_NUM_ROW + `SYA_NUM_COL - 1;
    localparam int FLUSH_W   = $clog2(FLUSH_LEN);
    // Counter slots from innermost outward
    localparam int I_CHN = 0;
    localparam int I_GRP = 1;
    localparam int I_FLT = 2;
    localparam int I_IFM = 3;

    ctrl_state_t                state;
    ctrl_state_t                state_nxt;
    sya_cfg_t                   cfg_q;
    logic [3:0][`SYA_IDX_W-1:0] cnt;
    logic [3:0][`SYA_IDX_W-1:0] cnt_max;
    logic [3:0]                 cnt_last;
    logic [3:0]                 cnt_inc;
    logic                       inc_inner;
    logic                       inc_outer;
    logic [`SYA_IDX_W-1:0]      chn_x_grp;
    logic [`SYA_IDX_W-1:0]      beat_cnt;
    logic [`SYA_IDX_W-1:0]      blk_seq;
    logic [FLUSH_W-1:0]         flush_cnt;
    logic                       req_done;
    logic                       cfg_done;
    logic                       cfg_fire;
    logic                       req_fire;
    logic                       dat_fire;
    logic                       blk_fire;
    logic                       beat_last;
    logic                       flush_last;

    assign cfg_ready    = (state == CTRL_IDLE);
    assign rd_req_valid = (state == CTRL_FEED) && !req_done;
    assign rd_dat_ready = (state == CTRL_FEED);
    assign blk_valid    = (state == CTRL_HANDOFF);

    assign cfg_fire = cfg_valid && cfg_ready;
    assign req_fire = rd_req_valid && rd_req_ready;
    assign dat_fire = rd_dat_valid && rd_dat_ready;
    assign blk_fire = blk_valid && blk_ready;

    // Flush cycles keep the array moving with empty operands
    assign step_en  = dat_fire || (state == CTRL_FLUSH);
    assign step_vld = dat_fire;
    assign clear    = blk_fire;

    assign beat_last  = (beat_cnt == cfg_q.num_chn - 1'b1);
    assign flush_last = (flush_cnt == FLUSH_W'(FLUSH_LEN - 1));

    // ========================================================================
    // Loop counters
    // ========================================================================
    always_comb begin
        cnt_max[I_CHN] = cfg_q.num_chn - 1'b1;
        cnt_max[I_GRP] = cfg_q.num_grp - 1'b1;
        cnt_max[I_FLT] = cfg_q.num_til_flt - 1'b1;
        cnt_max[I_IFM] = cfg_q.num_til_ifm - 1'b1;
        for (int i = 0; i < 4; i++) begin
            cnt_last[i] = (cnt[i] == cnt_max[i]);
        end
    end

    // Loop order picks which tile counter sits inside the other
    assign inc_inner = cnt_inc[I_GRP] && cnt_last[I_GRP];
    assign inc_outer = inc_inner && ((cfg_q.loop_ord == LOOP_FLT_INNER) ?
                                     cnt_last[I_FLT] : cnt_last[I_IFM]);

    assign cnt_inc[I_CHN] = req_fire;
    assign cnt_inc[I_GRP] = req_fire && cnt_last[I_CHN];
    assign cnt_inc[I_FLT] = (cfg_q.loop_ord == LOOP_FLT_INNER) ? inc_inner : inc_outer;
    assign cnt_inc[I_IFM] = (cfg_q.loop_ord == LOOP_FLT_INNER) ? inc_outer : inc_inner;

    always_ff @(posedge clk) begin
        if (cfg_fire) begin
            cfg_q <= cfg;
        end
    end

    // ========================================================================
    // State machine and phase counters
    // ========================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            CTRL_IDLE:    if (cfg_fire) state_nxt = CTRL_FEED;
            CTRL_FEED:    if (dat_fire && beat_last) state_nxt = CTRL_FLUSH;
            CTRL_FLUSH:   if (flush_last) state_nxt = CTRL_HANDOFF;
            CTRL_HANDOFF: if (blk_fire) state_nxt = cfg_done ? CTRL_IDLE : CTRL_FEED;
            default:      state_nxt = CTRL_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= CTRL_IDLE;
            cnt       <= '0;
            beat_cnt  <= '0;
            flush_cnt <= '0;
            blk_seq   <= '0;
            req_done  <= 1'b0;
            cfg_done  <= 1'b0;
        end else begin
            state <= state_nxt;
            if (cfg_fire) begin
                cnt      <= '0;
                blk_seq  <= '0;
                cfg_done <= 1'b0;
            end else begin
                for (int i = 0; i < 4; i++) begin
                    if (cnt_inc[i]) begin
                        cnt[i] <= cnt_last[i] ? '0 : cnt[i] + 1'b1;
                    end
                end
                if (req_fire && (&cnt_last)) begin
                    cfg_done <= 1'b1;
                end
                if (blk_fire) begin
                    blk_seq <= blk_seq + 1'b1;
                end
            end
            if (dat_fire) begin
                beat_cnt <= beat_last ? '0 : beat_cnt + 1'b1;
            end
            if (state == CTRL_FLUSH) begin
                flush_cnt <= flush_last ? '0 : flush_cnt + 1'b1;
            end
            // Requests for one block stop at its last channel
            if (blk_fire) begin
                req_done <= 1'b0;
            end else if (req_fire && cnt_last[I_CHN]) begin
                req_done <= 1'b1;
            end
        end
    end

    // ========================================================================
    // Read addresses and block hand-off
    // ========================================================================
    assign chn_x_grp = cfg_q.num_chn * cfg_q.num_grp;

    assign rd_req.act_addr = cfg_q.act_base + chn_x_grp * cnt[I_IFM]
                           + cfg_q.num_chn * cnt[I_GRP] + cnt[I_CHN];
    assign rd_req.wgt_addr = cfg_q.wgt_base + chn_x_grp * cnt[I_FLT]
                           + cfg_q.num_chn * cnt[I_GRP] + cnt[I_CHN];

    assign blk.psums    = psums;
    assign blk.ofm_addr = cfg_q.ofm_base + `SYA_ADDR_W'(blk_seq * `SYA_NUM_ROW);
    assign blk.shift    = cfg_q.shift;
    assign blk.zp       = cfg_q.zp;

    // Request payload holds until the memory takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req));

    // A new configuration finds no block half fed or half flushed
    assert property (@(posedge clk) disable iff (!rst_n)
        cfg_ready |-> !req_done && beat_cnt == '0 && flush_cnt == '0);

endmodule

`default_nettype wire

/* source/sya_pe_array.sv */
`timescale 1ns/1ns
`include "sya_macros.svh"
`default_nettype none

module sya_pe_array (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    step_en,
    input  logic                                    step_vld,
    input  logic                                    clear,
    input  logic [`SYA_NUM_ROW-1:0][`SYA_ACT_W-1:0] act_in,
    input  logic [`SYA_NUM_COL-1:0][`SYA_WGT_W-1:0] wgt_in,
    output sya_pkg::psum_block_t                    psums
);

    localparam int DEPTH = ((`SYA_NUM_ROW > `SYA_NUM_COL) ?
                            `SYA_NUM_ROW : `SYA_NUM_COL) - 1;

    // ========================================================================
    // Input skew
    // ========================================================================
    // Shared history of past inputs, row r and column c tap entry r-1, c-1
    logic [DEPTH-1:0][`SYA_NUM_ROW-1:0][`SYA_ACT_W-1:0] act_hist;
    logic [DEPTH-1:0][`SYA_NUM_COL-1:0][`SYA_WGT_W-1:0] wgt_hist;
    logic [DEPTH-1:0]                                   vld_hist;

    // Links between cells, index 0 is the skewed edge input
    logic [`SYA_ACT_W-1:0] act_h     [`SYA_NUM_ROW][`SYA_NUM_COL+1];
    logic                  act_vld_h [`SYA_NUM_ROW][`SYA_NUM_COL+1];
    logic [`SYA_WGT_W-1:0] wgt_v     [`SYA_NUM_ROW+1][`SYA_NUM_COL];
    logic                  wgt_vld_v [`SYA_NUM_ROW+1][`SYA_NUM_COL];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_hist <= '0;
        end else if (step_en) begin
            vld_hist[0] <= step_vld;
            for (int d = 1; d < DEPTH; d++) begin
                vld_hist[d] <= vld_hist[d-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step_en) begin
            act_hist[0] <= act_in;
            wgt_hist[0] <= wgt_in;
            for (int d = 1; d < DEPTH; d++) begin
                act_hist[d] <= act_hist[d-1];
                wgt_hist[d] <= wgt_hist[d-1];
            end
        end
    end

    for (genvar r = 0; r < `SYA_NUM_ROW; r++) begin : g_act_edge
        if (r == 0) begin : g_direct
            assign act_h[r][0]     = act_in[r];
            assign act_vld_h[r][0] = step_vld;
        end else begin : g_delayed
            assign act_h[r][0]     = act_hist[r-1][r];
            assign act_vld_h[r][0] = vld_hist[r-1];
        end
    end

    for (genvar c = 0; c < `SYA_NUM_COL; c++) begin : g_wgt_edge
        if (c == 0) begin : g_direct
            assign wgt_v[0][c]     = wgt_in[c];
            assign wgt_vld_v[0][c] = step_vld;
        end else begin : g_delayed
            assign wgt_v[0][c]     = wgt_hist[c-1][c];
            assign wgt_vld_v[0][c] = vld_hist[c-1];
        end
    end

    // ========================================================================
    // Cell grid
    // ========================================================================
    for (genvar r = 0; r < `SYA_NUM_ROW; r++) begin : g_row
        for (genvar c = 0; c < `SYA_NUM_COL; c++) begin : g_col
            sya_pe u_pe (
                .clk       (clk),
                .rst_n     (rst_n),
                .en        (step_en),
                .clear     (clear),
                .act_w     (act_h[r][c]),
                .act_vld_w (act_vld_h[r][c]),
                .wgt_n     (wgt_v[r][c]),
                .wgt_vld_n (wgt_vld_v[r][c]),
                .act_e     (act_h[r][c+1]),
                .act_vld_e (act_vld_h[r][c+1]),
                .wgt_s     (wgt_v[r+1][c]),
                .wgt_vld_s (wgt_vld_v[r+1][c]),
                .psum      (psums[r][c])
            );
        end
    end

endmodule

`default_nettype wire

/* source/sya_pe.sv */
`timescale 1ns/1ns
`include "sya_macros.svh"
`default_nettype none

module sya_pe (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  logic                   clear,
    input  logic [`SYA_ACT_W-1:0]  act_w,
    input  logic                   act_vld_w,
    input  logic [`SYA_WGT_W-1:0]  wgt_n,
    input  logic                   wgt_vld_n,
    output logic [`SYA_ACT_W-1:0]  act_e,
    output logic                   act_vld_e,
    output logic [`SYA_WGT_W-1:0]  wgt_s,
    output logic                   wgt_vld_s,
    output logic [`SYA_PSUM_W-1:0] psum
);

    logic signed [`SYA_ACT_W+`SYA_WGT_W-1:0] prod;
    logic signed [`SYA_PSUM_W-1:0]           acc;

    // Operates on the registered pair, the same one passed on
    assign prod = $signed(act_e) * $signed(wgt_s);
    assign psum = acc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_vld_e <= 1'b0;
            wgt_vld_s <= 1'b0;
            acc       <= '0;
        end else begin
            if (en) begin
                act_vld_e <= act_vld_w;
                wgt_vld_s <= wgt_vld_n;
            end
            if (clear) begin
                acc <= '0;
            end else if (en && act_vld_e && wgt_vld_s) begin
                acc <= acc + prod;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            act_e <= act_w;
            wgt_s <= wgt_n;
        end
    end

endmodule

`default_nettype wire

/* source/sya_pkg.sv */
`include "sya_macros.svh"
`default_nettype none

package sya_pkg;

    // ========================================================================
    // Enums
    // ========================================================================
    typedef enum logic {
        LOOP_FLT_INNER = 1'b0,
        LOOP_IFM_INNER = 1'b1
    } loop_ord_t;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_FEED,
        CTRL_FLUSH,
        CTRL_HANDOFF
    } ctrl_state_t;

    // ========================================================================
    // Channel payloads
    // ========================================================================
    typedef struct packed {
        logic [`SYA_ADDR_W-1:0] act_base;
        logic [`SYA_ADDR_W-1:0] wgt_base;
        logic [`SYA_ADDR_W-1:0] ofm_base;
        logic [`SYA_IDX_W-1:0]  num_chn;
        logic [`SYA_IDX_W-1:0]  num_grp;
        logic [`SYA_IDX_W-1:0]  num_til_ifm;
        logic [`SYA_IDX_W-1:0]  num_til_flt;
        logic [7:0]             shift;
        logic [7:0]             zp;
        loop_ord_t              loop_ord;
    } sya_cfg_t;

    typedef struct packed {
        logic [`SYA_ADDR_W-1:0] act_addr;
        logic [`SYA_ADDR_W-1:0] wgt_addr;
    } rd_req_t;

    typedef struct packed {
        logic [`SYA_NUM_ROW-1:0][`SYA_ACT_W-1:0] act;
        logic [`SYA_NUM_COL-1:0][`SYA_WGT_W-1:0] wgt;
    } rd_dat_t;

    typedef logic [`SYA_NUM_ROW-1:0][`SYA_NUM_COL-1:0][`SYA_PSUM_W-1:0] psum_block_t;

    // One finished block on its way to the writer
    typedef struct packed {
        psum_block_t            psums;
        logic [`SYA_ADDR_W-1:0] ofm_addr;
        logic [7:0]             shift;
        logic [7:0]             zp;
    } blk_t;

    typedef struct packed {
        logic [`SYA_ADDR_W-1:0]                  addr;
        logic [`SYA_NUM_COL-1:0][`SYA_ACT_W-1:0] dat;
    } ofm_wr_t;

endpackage

`default_nettype wire

/* source/sya_macros.svh */
`ifndef SYA_MACROS_SVH
`define SYA_MACROS_SVH
`default_nettype none

// Array geometry
`define SYA_NUM_ROW 4
`define SYA_NUM_COL 4

// Signed operand widths
`define SYA_ACT_W   8
`define SYA_WGT_W   8

// Accumulator and buffer widths
`define SYA_PSUM_W  32
`define SYA_ADDR_W  16

// Loop counts
`define SYA_IDX_W   16

`default_nettype wire
`endif
